// ==== hdl/mpmem_pkg.sv ====
`default_nettype none

package mpmem_pkg;

  localparam int NUM_BANK = 4;
  localparam int NUM_ROW  = 16;
  localparam int DATA_W   = 16;
  localparam int BANK_W   = 2;
  localparam int ROW_W    = 4;
  localparam int ADDR_W   = BANK_W + ROW_W;  // Bank in the high bits and row in the low bits

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // A map entry holds a valid flag on top of the bank whose copy sits in the cache
  typedef logic [BANK_W:0]   map_t;

  typedef enum logic {
    SWEEP,  // Map table is being cleared after reset
    RUN
  } place_state_t;

endpackage

`default_nettype wire

// ==== hdl/mpmem_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decoded requests, one cycle after the port registers
interface mem_req_if;
  import mpmem_pkg::*;

  logic  wa_vld;
  bank_t wa_bank;
  row_t  wa_row;
  data_t wa_data;
  logic  wb_vld;
  bank_t wb_bank;
  row_t  wb_row;
  data_t wb_data;
  logic  rd_vld;
  bank_t rd_bank;
  row_t  rd_row;

  modport place (
    input wa_vld, wa_bank, wa_row, wa_data,
    input wb_vld, wb_bank, wb_row, wb_data
  );

  modport lookup (input rd_vld, rd_bank, rd_row);
endinterface

// Two commit slots into the data banks that never name the same bank at once
interface bank_write_if;
  import mpmem_pkg::*;

  logic  en0;
  bank_t bank0;
  row_t  row0;
  data_t data0;
  logic  en1;
  bank_t bank1;
  row_t  row1;
  data_t data1;

  modport commit (output en0, bank0, row0, data0, en1, bank1, row1, data1);
  modport bank (input en0, bank0, row0, data0, en1, bank1, row1, data1);
  modport snoop (input en0, bank0, row0, data0, en1, bank1, row1, data1);
endinterface

`default_nettype wire

// ==== hdl/addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_decode (
  input  logic              clk,
  input  logic              rstvld,
  input  logic              ready,
  input  logic              write_a,
  input  mpmem_pkg::addr_t  write_a_addr,
  input  mpmem_pkg::data_t  write_a_data,
  input  logic              write_b,
  input  mpmem_pkg::addr_t  write_b_addr,
  input  mpmem_pkg::data_t  write_b_data,
  input  logic              read,
  input  mpmem_pkg::addr_t  read_addr,
  mem_req_if                req
);
  import mpmem_pkg::*;

  logic  in_wa;
  addr_t in_wa_addr;
  data_t in_wa_data;
  logic  in_wb;
  addr_t in_wb_addr;
  data_t in_wb_data;
  logic  in_rd;
  addr_t in_rd_addr;
  logic  wa_shadowed;

  assign wa_shadowed = in_wb && (in_wa_addr == in_wb_addr);  // Port B wins on a shared address

  always_ff @(posedge clk) begin
    if (rstvld) begin
      in_wa      <= 1'b0;
      in_wb      <= 1'b0;
      in_rd      <= 1'b0;
      req.wa_vld <= 1'b0;
      req.wb_vld <= 1'b0;
      req.rd_vld <= 1'b0;
    end else begin
      in_wa      <= write_a && ready;  // Requests before the end of the sweep are dropped
      in_wb      <= write_b && ready;
      in_rd      <= read && ready;
      req.wa_vld <= in_wa && !wa_shadowed;
      req.wb_vld <= in_wb;
      req.rd_vld <= in_rd;
    end
  end

  always_ff @(posedge clk) begin
    in_wa_addr  <= write_a_addr;
    in_wa_data  <= write_a_data;
    in_wb_addr  <= write_b_addr;
    in_wb_data  <= write_b_data;
    in_rd_addr  <= read_addr;
    req.wa_bank <= in_wa_addr[ADDR_W-1:ROW_W];
    req.wa_row  <= in_wa_addr[ROW_W-1:0];
    req.wa_data <= in_wa_data;
    req.wb_bank <= in_wb_addr[ADDR_W-1:ROW_W];
    req.wb_row  <= in_wb_addr[ROW_W-1:0];
    req.wb_data <= in_wb_data;
    req.rd_bank <= in_rd_addr[ADDR_W-1:ROW_W];
    req.rd_row  <= in_rd_addr[ROW_W-1:0];
  end

endmodule

`default_nettype wire

// ==== hdl/row_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_table #(
  parameter int ENTRY_W = 16
) (
  input  logic               clk,
  input  logic               we,
  input  mpmem_pkg::row_t    wr_row,
  input  logic [ENTRY_W-1:0] wr_data,
  input  mpmem_pkg::row_t    rd_row_a,
  input  mpmem_pkg::row_t    rd_row_b,
  input  mpmem_pkg::row_t    rd_row_c,
  output logic [ENTRY_W-1:0] rd_data_a,
  output logic [ENTRY_W-1:0] rd_data_b,
  output logic [ENTRY_W-1:0] rd_data_c
);
  import mpmem_pkg::*;

  logic [ENTRY_W-1:0] mem [NUM_ROW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
    rd_data_a <= mem[rd_row_a];
    rd_data_b <= mem[rd_row_b];
    rd_data_c <= mem[rd_row_c];
  end

endmodule

`default_nettype wire

// ==== hdl/data_bank_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_bank_array (
  input  logic             clk,
  bank_write_if.bank       wr,
  input  mpmem_pkg::bank_t rd_bank,
  input  mpmem_pkg::row_t  rd_row,
  output mpmem_pkg::data_t rd_data
);
  import mpmem_pkg::*;

  data_t mem [NUM_BANK][NUM_ROW];

  // Each bank takes at most one of the two slots, so every bank keeps a single write port
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BANK; b++) begin
      if (wr.en0 && (wr.bank0 == bank_t'(b))) begin
        mem[b][wr.row0] <= wr.data0;
      end else if (wr.en1 && (wr.bank1 == bank_t'(b))) begin
        mem[b][wr.row1] <= wr.data1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_bank][rd_row];  // Old word when written on the same edge
  end

endmodule

`default_nettype wire

// ==== hdl/write_placement.sv ====
`timescale 1ns/100ps
`default_nettype none

module write_placement (
  input  logic             clk,
  input  logic             rstvld,
  mem_req_if.place         req,
  bank_write_if.commit     commit,
  input  mpmem_pkg::map_t  map_rd_a,
  input  mpmem_pkg::map_t  map_rd_b,
  input  mpmem_pkg::data_t cache_rd_b,
  output logic             cache_we,
  output mpmem_pkg::row_t  cache_row,
  output mpmem_pkg::data_t cache_din,
  output logic             map_we,
  output mpmem_pkg::row_t  map_row,
  output mpmem_pkg::map_t  map_din,
  output logic             ready
);
  import mpmem_pkg::*;

  place_state_t state;
  row_t         clr_row;
  logic         a_vld;
  bank_t        a_bank;
  row_t         a_row;
  data_t        a_data;
  logic         b_vld;
  bank_t        b_bank;
  row_t         b_row;
  data_t        b_data;
  logic         fm_we;
  row_t         fm_row;
  map_t         fm_din;
  logic         fc_we;
  row_t         fc_row;
  data_t        fc_din;
  map_t         map_a;
  map_t         map_b;
  data_t        cache_b;
  logic         a_to_cache;
  logic         b_to_cache;
  logic         b_inval;
  logic         b_wback;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state   <= SWEEP;
      clr_row <= '0;
      ready   <= 1'b0;
    end else if (state == SWEEP) begin
      clr_row <= clr_row + 1'b1;
      if (clr_row == row_t'(NUM_ROW - 1)) begin
        state <= RUN;
        ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstvld) begin
      a_vld <= 1'b0;
      b_vld <= 1'b0;
      fm_we <= 1'b0;
      fc_we <= 1'b0;
    end else begin
      a_vld <= req.wa_vld;
      b_vld <= req.wb_vld;
      fm_we <= map_we;
      fc_we <= cache_we;
    end
  end

  always_ff @(posedge clk) begin
    a_bank <= req.wa_bank;
    a_row  <= req.wa_row;
    a_data <= req.wa_data;
    b_bank <= req.wb_bank;
    b_row  <= req.wb_row;
    b_data <= req.wb_data;
    fm_row <= map_row;
    fm_din <= map_din;
    fc_row <= cache_row;
    fc_din <= cache_din;
  end

  // The table reads miss the write made on the same edge, so that write is replayed here
  assign map_a   = (fm_we && (fm_row == a_row)) ? fm_din : map_rd_a;
  assign map_b   = (fm_we && (fm_row == b_row)) ? fm_din : map_rd_b;
  assign cache_b = (fc_we && (fc_row == b_row)) ? fc_din : cache_rd_b;

  assign a_to_cache = a_vld && map_a[BANK_W] && (map_a[BANK_W-1:0] == a_bank);
  assign b_to_cache = a_vld && b_vld && !a_to_cache && (a_bank == b_bank);
  assign b_inval    = b_vld && !b_to_cache && map_b[BANK_W] && (map_b[BANK_W-1:0] == b_bank);
  assign b_wback    = b_to_cache && map_b[BANK_W] && (map_b[BANK_W-1:0] != b_bank);

  assign commit.en0   = a_vld && !a_to_cache;
  assign commit.bank0 = a_bank;
  assign commit.row0  = a_row;
  assign commit.data0 = a_data;
  assign commit.en1   = (b_vld && !b_to_cache) || b_wback;  // Displaced cache entry goes home
  assign commit.bank1 = b_to_cache ? map_b[BANK_W-1:0] : b_bank;
  assign commit.row1  = b_row;
  assign commit.data1 = b_to_cache ? cache_b : b_data;

  assign cache_we  = a_to_cache || b_to_cache;
  assign cache_row = a_to_cache ? a_row : b_row;
  assign cache_din = a_to_cache ? a_data : b_data;

  always_comb begin
    map_we  = b_inval;
    map_row = b_row;
    map_din = '0;
    if (state == SWEEP) begin
      map_we  = 1'b1;
      map_row = clr_row;
    end else if (b_to_cache) begin
      map_we  = 1'b1;
      map_din = {1'b1, b_bank};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/read_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_select (
  input  logic             clk,
  input  logic             rstvld,
  mem_req_if.lookup        req,
  bank_write_if.snoop      snoop,
  input  logic             cache_we,
  input  mpmem_pkg::row_t  cache_row,
  input  mpmem_pkg::data_t cache_din,
  input  logic             map_we,
  input  mpmem_pkg::row_t  map_row,
  input  mpmem_pkg::map_t  map_din,
  input  mpmem_pkg::data_t bank_data,
  input  mpmem_pkg::data_t cache_data,
  input  mpmem_pkg::map_t  map_data,
  output logic             read_valid,
  output mpmem_pkg::data_t read_data
);
  import mpmem_pkg::*;

  logic  rv_q;
  bank_t rbank_q;
  row_t  rrow_q;
  logic  s_en0;
  bank_t s_bank0;
  row_t  s_row0;
  data_t s_data0;
  logic  s_en1;
  bank_t s_bank1;
  row_t  s_row1;
  data_t s_data1;
  logic  s_cwe;
  row_t  s_crow;
  data_t s_cdin;
  logic  s_mwe;
  row_t  s_mrow;
  map_t  s_mdin;
  map_t  map_eff;
  data_t cache_eff;
  data_t bank_eff;
  data_t sel_data;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      rv_q       <= 1'b0;
      s_en0      <= 1'b0;
      s_en1      <= 1'b0;
      s_cwe      <= 1'b0;
      s_mwe      <= 1'b0;
      read_valid <= 1'b0;
    end else begin
      rv_q       <= req.rd_vld;
      s_en0      <= snoop.en0;
      s_en1      <= snoop.en1;
      s_cwe      <= cache_we;
      s_mwe      <= map_we;
      read_valid <= rv_q;
    end
  end

  always_ff @(posedge clk) begin
    rbank_q   <= req.rd_bank;
    rrow_q    <= req.rd_row;
    s_bank0   <= snoop.bank0;
    s_row0    <= snoop.row0;
    s_data0   <= snoop.data0;
    s_bank1   <= snoop.bank1;
    s_row1    <= snoop.row1;
    s_data1   <= snoop.data1;
    s_crow    <= cache_row;
    s_cdin    <= cache_din;
    s_mrow    <= map_row;
    s_mdin    <= map_din;
    read_data <= sel_data;
  end

  // Commits landing on the table read edge are not in the read data yet
  always_comb begin
    map_eff   = (s_mwe && (s_mrow == rrow_q)) ? s_mdin : map_data;
    cache_eff = (s_cwe && (s_crow == rrow_q)) ? s_cdin : cache_data;
    bank_eff  = bank_data;
    if (s_en0 && (s_bank0 == rbank_q) && (s_row0 == rrow_q)) begin
      bank_eff = s_data0;
    end else if (s_en1 && (s_bank1 == rbank_q) && (s_row1 == rrow_q)) begin
      bank_eff = s_data1;
    end
    sel_data = (map_eff[BANK_W] && (map_eff[BANK_W-1:0] == rbank_q)) ? cache_eff : bank_eff;
  end

endmodule

`default_nettype wire

// ==== hdl/mpmem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpmem_top (
  input  logic             clk,
  input  logic             rstvld,
  input  logic             write_a,
  input  mpmem_pkg::addr_t write_a_addr,
  input  mpmem_pkg::data_t write_a_data,
  input  logic             write_b,
  input  mpmem_pkg::addr_t write_b_addr,
  input  mpmem_pkg::data_t write_b_data,
  input  logic             read,
  input  mpmem_pkg::addr_t read_addr,
  output logic             ready,
  output logic             read_valid,
  output mpmem_pkg::data_t read_data
);
  import mpmem_pkg::*;

  map_t  map_rd_a;
  map_t  map_rd_b;
  map_t  map_rd_c;
  data_t cache_rd_b;
  data_t cache_rd_c;
  data_t bank_rd_data;
  logic  cache_we;
  row_t  cache_row;
  data_t cache_din;
  logic  map_we;
  row_t  map_row;
  map_t  map_din;

  mem_req_if    req_if ();
  bank_write_if bw_if ();

  addr_decode u_decode (
    .clk, .rstvld, .ready,
    .write_a, .write_a_addr, .write_a_data,
    .write_b, .write_b_addr, .write_b_data,
    .read, .read_addr,
    .req (req_if)
  );

  write_placement u_place (
    .clk, .rstvld,
    .req (req_if.place), .commit (bw_if.commit),
    .map_rd_a, .map_rd_b, .cache_rd_b,
    .cache_we, .cache_row, .cache_din,
    .map_we, .map_row, .map_din,
    .ready
  );

  data_bank_array u_banks (
    .clk, .wr (bw_if.bank),
    .rd_bank (req_if.rd_bank), .rd_row (req_if.rd_row), .rd_data (bank_rd_data)
  );

  row_table #(.ENTRY_W (DATA_W)) u_cache (
    .clk, .we (cache_we), .wr_row (cache_row), .wr_data (cache_din),
    .rd_row_a (req_if.wa_row), .rd_row_b (req_if.wb_row), .rd_row_c (req_if.rd_row),
    .rd_data_a (), .rd_data_b (cache_rd_b), .rd_data_c (cache_rd_c)  // Write A never reads the cache
  );

  row_table #(.ENTRY_W ($bits(map_t))) u_map (
    .clk, .we (map_we), .wr_row (map_row), .wr_data (map_din),
    .rd_row_a (req_if.wa_row), .rd_row_b (req_if.wb_row), .rd_row_c (req_if.rd_row),
    .rd_data_a (map_rd_a), .rd_data_b (map_rd_b), .rd_data_c (map_rd_c)
  );

  read_select u_select (
    .clk, .rstvld,
    .req (req_if.lookup), .snoop (bw_if.snoop),
    .cache_we, .cache_row, .cache_din,
    .map_we, .map_row, .map_din,
    .bank_data (bank_rd_data), .cache_data (cache_rd_c), .map_data (map_rd_c),
    .read_valid, .read_data
  );

endmodule

`default_nettype wire

// ==== tests/mpmem_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpmem_assert (
  input logic                    clk,
  input logic                    rstvld,
  input mpmem_pkg::place_state_t state,
  input logic                    ready,
  input logic                    en0,
  input mpmem_pkg::bank_t        bank0,
  input logic                    en1,
  input mpmem_pkg::bank_t        bank1
);
  import mpmem_pkg::*;

  // Each bank has a single write port
  commit_banks_differ: assert property (@(posedge clk) disable iff (rstvld)
    (en0 && en1) |-> (bank0 != bank1))
    else $error("Both commit slots name bank %0d", bank0);

  no_commit_in_sweep: assert property (@(posedge clk) disable iff (rstvld)
    (state != RUN) |-> !(en0 || en1))
    else $error("Commit enabled while the map sweep runs");

  ready_follows_run: assert property (@(posedge clk) disable iff (rstvld)
    ready == (state == RUN))
    else $error("ready does not match the placement state");

endmodule

bind write_placement mpmem_assert u_assert (
  .clk    (clk),
  .rstvld (rstvld),
  .state  (state),
  .ready  (ready),
  .en0    (commit.en0),
  .bank0  (commit.bank0),
  .en1    (commit.en1),
  .bank1  (commit.bank1)
);

`default_nettype wire

// ==== tests/tb_mpmem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mpmem;
  import mpmem_pkg::*;

  localparam int N_RAND      = 300;
  localparam int TEST_CYCLES = 8 * 4 + 8 * 3 + 4 * (NUM_ROW + 64) + 4 * 2 + N_RAND;
  localparam int CYCLE_LIMIT = 4 + NUM_ROW + 4 + TEST_CYCLES + 100;

  logic   clk;
  logic   rstvld;
  logic   write_a;
  addr_t  write_a_addr;
  data_t  write_a_data;
  logic   write_b;
  addr_t  write_b_addr;
  data_t  write_b_data;
  logic   read;
  addr_t  read_addr;
  logic   ready;
  logic   read_valid;
  data_t  read_data;

  data_t  ref_mem [1 << ADDR_W];
  data_t  exp_data [$];
  int     exp_due [$];
  int     cycle;
  int     errors;
  int     n_checked;
  integer seed;

  mpmem_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // The read sees the memory before this edge, then A and B land in that order so B wins
  function automatic data_t ref_read(input logic wa, input addr_t wa_addr, input data_t wa_data,
                                     input logic wb, input addr_t wb_addr, input data_t wb_data,
                                     input addr_t rd_addr);
    data_t rd_word;
    rd_word = ref_mem[rd_addr];
    if (wa)
      ref_mem[wa_addr] = wa_data;
    if (wb)
      ref_mem[wb_addr] = wb_data;
    return rd_word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic apply_cycle(input logic wa, input addr_t wa_addr, input data_t wa_data,
                             input logic wb, input addr_t wb_addr, input data_t wb_data,
                             input logic rd, input addr_t rd_addr);
    data_t expected;
    @(negedge clk);
    write_a      = wa;
    write_a_addr = wa_addr;
    write_a_data = wa_data;
    write_b      = wb;
    write_b_addr = wb_addr;
    write_b_data = wb_data;
    read         = rd;
    read_addr    = rd_addr;
    check_value("ready", ready, 1);
    expected = ref_read(wa, wa_addr, wa_data, wb, wb_addr, wb_data, rd_addr);
    if (rd) begin
      exp_data.push_back(expected);
      exp_due.push_back(cycle + 4);  // Sampled at the next edge and valid three edges later
    end
  endtask

  task automatic drain_reads();
    while (exp_due.size() != 0)
      apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
  endtask

  always @(posedge clk) begin
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles with the tests still running", cycle);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (exp_due.size() != 0 && exp_due[0] == cycle) begin
      check_value("read_valid", read_valid, 1);
      check_value("read_data", read_data, exp_data[0]);
      n_checked++;
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
    end else if (read_valid === 1'b1) begin
      errors++;
      $display("At %0t ns read_valid is high with no read pending", $time);
    end
  end

  initial begin
    addr_t       a;
    addr_t       b;
    addr_t       last_addr;
    logic [31:0] rnd;
    logic [31:0] dat;
    seed      = 32'hc956;
    cycle     = 0;
    errors    = 0;
    n_checked = 0;
    rstvld    = 1'b1;
    write_a   = 1'b0;
    write_a_addr = '0;
    write_a_data = '0;
    write_b   = 1'b0;
    write_b_addr = '0;
    write_b_data = '0;
    read      = 1'b0;
    read_addr = '0;
    for (int i = 0; i < (1 << ADDR_W); i++)
      ref_mem[i] = '0;

    repeat (4) @(negedge clk);
    check_value("ready", ready, 0);
    rstvld = 1'b0;
    for (int i = 0; i < NUM_ROW - 1; i++) begin  // Map sweep in progress
      @(negedge clk);
      check_value("ready", ready, 0);
      check_value("read_valid", read_valid, 0);
    end
    @(negedge clk);
    check_value("ready", ready, 1);

    for (int i = 0; i < 8; i++) begin
      a = addr_t'(i * 9);
      b = addr_t'(i * 7 + 3);
      apply_cycle(1'b1, a, data_t'(16'h1100 + i), 1'b0, '0, '0, 1'b0, '0);
      apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, a);
      apply_cycle(1'b0, '0, '0, 1'b1, b, data_t'(16'h2200 + i), 1'b0, '0);
      apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, b);
    end
    drain_reads();

    for (int i = 0; i < 8; i++) begin
      a = {bank_t'(i), row_t'(i * 3)};
      b = {bank_t'(i + 1), row_t'(i * 5)};
      apply_cycle(1'b1, a, data_t'(16'h3300 + i), 1'b1, b, data_t'(16'h4400 + i), 1'b0, '0);
      apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, a);
      apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, b);
    end
    drain_reads();

    // Same bank on both ports with the bank rotating per pass to force write-backs
    for (int p = 0; p < 4; p++) begin
      for (int r = 0; r < NUM_ROW; r++) begin
        a = {bank_t'(r + p), row_t'(r)};
        b = {bank_t'(r + p), row_t'(r + 5)};
        apply_cycle(1'b1, a, {p[3:0], r[3:0], 8'h5a}, 1'b1, b, {p[3:0], r[3:0], 8'hb5}, 1'b0, '0);
      end
      for (int i = 0; i < (1 << ADDR_W); i++)
        apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, addr_t'(i));
    end
    drain_reads();

    for (int i = 0; i < 4; i++) begin
      a = addr_t'(i * 17 + 2);
      apply_cycle(1'b1, a, data_t'(16'h6600 + i), 1'b1, a, data_t'(16'h7700 + i), 1'b1, a);
      apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, a);
    end
    drain_reads();

    last_addr = '0;
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      dat = $random(seed);
      a   = rnd[5:0];
      b   = (rnd[7:6] == 2'b00) ? a : rnd[13:8];
      apply_cycle(rnd[16], a, dat[15:0], rnd[17], b, dat[31:16], rnd[18] | rnd[19],
                  rnd[20] ? last_addr : rnd[29:24]);
      if (rnd[17])
        last_addr = b;
      else if (rnd[16])
        last_addr = a;
    end
    drain_reads();

    $display("Compared %0d reads, %0d errors", n_checked, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/mpmem_pkg.sv
hdl/mpmem_if.sv
hdl/addr_decode.sv
hdl/row_table.sv
hdl/data_bank_array.sv
hdl/write_placement.sv
hdl/read_select.sv
hdl/mpmem_top.sv
tests/mpmem_assert.sv
tests/tb_mpmem.sv

// ==== Bender.yml ====
package:
  name: mpmem

sources:
  - hdl/mpmem_pkg.sv
  - hdl/mpmem_if.sv
  - hdl/addr_decode.sv
  - hdl/row_table.sv
  - hdl/data_bank_array.sv
  - hdl/write_placement.sv
  - hdl/read_select.sv
  - hdl/mpmem_top.sv
  - target: test
    files:
      - tests/mpmem_assert.sv
      - tests/tb_mpmem.sv
